// ==== logic/spi_flash_consts.svh ====
`ifndef SPI_FLASH_CONSTS_SVH
`define SPI_FLASH_CONSTS_SVH

// Field widths
`define SPI_DATA_W   32
`define SPI_CMD_W    8
`define SPI_ADDR_W   24
`define SPI_CTYP_W   3
`define SPI_NBITS_W  7
`define SPI_DUMMY_W  4
`define SPI_EDGES_W  9
`define SPI_FMT_W    8

// Lane codes, 2'b11 falls back to single
`define SPI_LANE_SINGLE 2'b00
`define SPI_LANE_DUAL   2'b01
`define SPI_LANE_QUAD   2'b10

// Frame format fields
`define SPI_FMT_CMD  7:6
`define SPI_FMT_ADDR 5:4
`define SPI_FMT_TX   3:2
`define SPI_FMT_RX   1:0

// Command types
`define SPI_CT_CMD         3'd0
`define SPI_CT_CMD_RD      3'd1
`define SPI_CT_CMD_ADDR_RD 3'd2
`define SPI_CT_CMD_WR      3'd3
`define SPI_CT_CMD_ADDR_WR 3'd4
`define SPI_CT_CMD_ADDR    3'd5

`endif

// ==== logic/spi_flash_pkg.sv ====
`include "spi_flash_consts.svh"

package spi_flash_pkg;

	typedef logic [`SPI_DATA_W-1:0]  data_t;
	typedef logic [`SPI_CMD_W-1:0]   cmd_t;
	typedef logic [`SPI_ADDR_W-1:0]  addr_t;
	typedef logic [`SPI_CTYP_W-1:0]  ctyp_t;
	typedef logic [`SPI_NBITS_W-1:0] nbits_t;
	typedef logic [`SPI_DUMMY_W-1:0] dummy_t;
	typedef logic [`SPI_EDGES_W-1:0] edges_t; // SCLK edges per frame
	typedef logic [1:0]              lane_t;

	// Master FSM
	typedef enum logic [1:0] {IDLE, SETUP, TRANSFER} ctrl_state_t;

	// Frame phases seen by the shifters
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CMD,
		PH_ADDR,
		PH_DUMMY,
		PH_TX,
		PH_RX
	} phase_t;

endpackage

// ==== logic/spi_frame_if.sv ====
`timescale 1ns/1ps

// One frame's description, controller to shifters
interface spi_frame_if;
	spi_flash_pkg::cmd_t   command;
	spi_flash_pkg::addr_t  address;
	spi_flash_pkg::data_t  tx_data;
	spi_flash_pkg::lane_t  cmd_lanes;
	spi_flash_pkg::lane_t  addr_lanes;
	spi_flash_pkg::lane_t  tx_lanes;
	spi_flash_pkg::lane_t  rx_lanes;
	logic                  has_addr;
	logic                  has_tx;
	logic                  has_rx;
	spi_flash_pkg::nbits_t tx_bits;
	spi_flash_pkg::nbits_t rx_bits;
	spi_flash_pkg::dummy_t dummy_cycles;
	logic                  start; // Transfer begins

	modport ctrl (output command, address, tx_data, cmd_lanes, addr_lanes, tx_lanes, rx_lanes,
		has_addr, has_tx, has_rx, tx_bits, rx_bits, dummy_cycles, start);
	modport tx (input command, address, tx_data, cmd_lanes, addr_lanes, tx_lanes,
		has_addr, has_tx, has_rx, tx_bits, dummy_cycles, start);
	modport rx (input rx_lanes, has_rx, rx_bits, dummy_cycles, start);
endinterface

// ==== logic/spi_sclk_gen.sv ====
`timescale 1ns/1ps

module spi_sclk_gen import spi_flash_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL = 1,
	parameter int CPHA = 1
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  edges_t edge_count,
	output logic   sclk,
	output logic   latch_in,
	output logic   latch_out,
	output logic   done
);

	localparam int DIV_W = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
	localparam logic IDLE_LVL = 1'(CPOL);
	localparam logic CPHA_ON = (CPHA != 0);

	logic             active;
	logic [DIV_W-1:0] div_cnt;
	edges_t           edges_left;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sclk <= IDLE_LVL;
			active <= 1'b0;
			div_cnt <= '0;
			edges_left <= '0;
			latch_in <= 1'b0;
			latch_out <= 1'b0;
			done <= 1'b0;
		end else begin
			latch_in <= 1'b0;
			latch_out <= 1'b0;
			if (start) begin
				sclk <= IDLE_LVL;
				active <= 1'b1;
				div_cnt <= '0;
				edges_left <= edge_count;
				done <= 1'b0;
				latch_out <= ~CPHA_ON; // First bit must be on the pins before the leading edge
			end else if (active) begin
				if (edges_left == '0) begin
					active <= 1'b0;
					done <= 1'b1;
				end else if (div_cnt == DIV_W'(CLKS_PER_HALF_SCLK - 1)) begin
					div_cnt <= '0;
					sclk <= ~sclk;
					edges_left <= edges_left - 1'b1;
					if (sclk == IDLE_LVL) begin // Leading edge
						latch_out <= CPHA_ON;
						latch_in <= ~CPHA_ON;
					end else begin
						latch_out <= ~CPHA_ON;
						latch_in <= CPHA_ON;
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/spi_frame_ctrl.sv ====
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_frame_ctrl import spi_flash_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  data_t                 data_in,
	input  addr_t                 address,
	input  cmd_t                  command,
	input  ctyp_t                 commtype,
	input  nbits_t                ndata_bits,
	input  dummy_t                dummy_cycles,
	input  logic [`SPI_FMT_W-1:0] frame_struct,
	input  logic                  validflag,
	input  data_t                 rx_data,
	input  logic                  sclk_done,
	spi_frame_if.ctrl             frame,
	output logic                  sclk_start,
	output edges_t                edge_count,
	output logic                  ss,
	output logic                  tready,
	output logic                  validflag_out,
	output data_t                 data_out
);

	ctrl_state_t           state;
	data_t                 r_data;
	addr_t                 r_addr;
	cmd_t                  r_cmd;
	ctyp_t                 r_ctyp;
	nbits_t                r_nbits;
	dummy_t                r_dummy;
	logic [`SPI_FMT_W-1:0] r_fmt;
	logic                  req_seen; // Request taken since validflag last fell
	logic                  accept;
	logic                  start_q;
	logic                  has_addr, has_tx, has_rx;
	lane_t                 cmd_lanes, addr_lanes, tx_lanes, rx_lanes;
	edges_t                cmd_cyc, addr_cyc, data_cyc, total_cyc;

	// Code 11 runs on one lane
	function automatic lane_t lane_norm(input lane_t code);
		if (code == `SPI_LANE_DUAL || code == `SPI_LANE_QUAD)
			return code;
		return `SPI_LANE_SINGLE;
	endfunction

	function automatic edges_t lane_cycles(input nbits_t bits, input lane_t lane);
		case (lane)
			`SPI_LANE_QUAD: return edges_t'(bits >> 2);
			`SPI_LANE_DUAL: return edges_t'(bits >> 1);
			default:        return edges_t'(bits);
		endcase
	endfunction

	assign accept = validflag && tready && !req_seen;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			req_seen <= 1'b0;
		else if (!validflag)
			req_seen <= 1'b0;
		else if (accept)
			req_seen <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			r_data <= data_in;
			r_addr <= address;
			r_cmd <= command;
			r_ctyp <= commtype;
			r_nbits <= ndata_bits;
			r_dummy <= dummy_cycles;
			r_fmt <= frame_struct;
		end
	end

	// Phases present per command type
	always_comb begin
		has_addr = 1'b0;
		has_tx = 1'b0;
		has_rx = 1'b0;
		case (r_ctyp)
			`SPI_CT_CMD:         ;
			`SPI_CT_CMD_RD:      has_rx = 1'b1;
			`SPI_CT_CMD_ADDR_RD: begin
				has_addr = 1'b1;
				has_rx = 1'b1;
			end
			`SPI_CT_CMD_WR:      has_tx = 1'b1;
			`SPI_CT_CMD_ADDR_WR: begin
				has_addr = 1'b1;
				has_tx = 1'b1;
			end
			`SPI_CT_CMD_ADDR:    has_addr = 1'b1;
			default:             ; // Unknown codes run as command only
		endcase
	end

	assign cmd_lanes  = lane_norm(r_fmt[`SPI_FMT_CMD]);
	assign addr_lanes = lane_norm(r_fmt[`SPI_FMT_ADDR]);
	assign tx_lanes   = lane_norm(r_fmt[`SPI_FMT_TX]);
	assign rx_lanes   = lane_norm(r_fmt[`SPI_FMT_RX]);

	// SCLK cycles per phase
	assign cmd_cyc = lane_cycles(nbits_t'(`SPI_CMD_W), cmd_lanes);
	assign addr_cyc = has_addr ?
		lane_cycles(nbits_t'(`SPI_ADDR_W), addr_lanes) + edges_t'(r_dummy) : '0;
	assign data_cyc = has_tx ? lane_cycles(r_nbits, tx_lanes) :
		has_rx ? lane_cycles(r_nbits, rx_lanes) : '0;
	assign total_cyc = cmd_cyc + addr_cyc + data_cyc;

	assign frame.command      = r_cmd;
	assign frame.address      = r_addr;
	assign frame.tx_data      = r_data;
	assign frame.cmd_lanes    = cmd_lanes;
	assign frame.addr_lanes   = addr_lanes;
	assign frame.tx_lanes     = tx_lanes;
	assign frame.rx_lanes     = rx_lanes;
	assign frame.has_addr     = has_addr;
	assign frame.has_tx       = has_tx;
	assign frame.has_rx       = has_rx;
	assign frame.tx_bits      = has_tx ? r_nbits : '0;
	assign frame.rx_bits      = has_rx ? r_nbits : '0;
	assign frame.dummy_cycles = has_addr ? r_dummy : '0;
	assign frame.start        = start_q;
	assign sclk_start         = start_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			start_q <= 1'b0;
			edge_count <= '0;
			ss <= 1'b1;
			tready <= 1'b1;
			validflag_out <= 1'b0;
			data_out <= '0;
		end else begin
			validflag_out <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						tready <= 1'b0;
						state <= SETUP;
					end
				end
				SETUP: begin
					edge_count <= total_cyc << 1; // Two edges per cycle
					start_q <= 1'b1;
					ss <= 1'b0;
					state <= TRANSFER;
				end
				TRANSFER: begin
					start_q <= 1'b0;
					// Done still holds the previous frame while start is high
					if (sclk_done && !start_q) begin
						ss <= 1'b1;
						tready <= 1'b1;
						validflag_out <= 1'b1;
						data_out <= rx_data;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== logic/spi_tx_shifter.sv ====
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_tx_shifter import spi_flash_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	spi_frame_if.tx    frame,
	input  logic       latch_out,
	input  logic       latch_in,
	output logic [3:0] dq_out,
	output logic [3:0] dq_oe,
	output logic       tx_done
);

	localparam int SH_W = `SPI_CMD_W + `SPI_ADDR_W + `SPI_DATA_W;
	localparam logic [3:0] IDLE_PINS = 4'b1100; // WP# and HOLD# inactive

	phase_t          phase;
	logic [SH_W-1:0] shreg;
	nbits_t          bits_left; // In the current phase
	nbits_t          step;
	lane_t           lane;
	logic            sending;
	logic            shift;

	always_comb begin
		case (phase)
			PH_ADDR: lane = frame.addr_lanes;
			PH_TX:   lane = frame.tx_lanes;
			default: lane = frame.cmd_lanes;
		endcase
		case (lane)
			`SPI_LANE_QUAD: step = nbits_t'(4);
			`SPI_LANE_DUAL: step = nbits_t'(2);
			default:        step = nbits_t'(1);
		endcase
	end

	assign shift = latch_out && (phase != PH_IDLE);

	// Bit string, MSB first
	always_ff @(posedge clk) begin
		if (frame.start)
			shreg <= frame.has_addr ? {frame.command, frame.address, frame.tx_data} :
				{frame.command, frame.tx_data, {`SPI_ADDR_W{1'b0}}};
		else if (shift)
			shreg <= shreg << step;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_IDLE;
			bits_left <= '0;
			sending <= 1'b0;
			tx_done <= 1'b0;
			dq_out <= IDLE_PINS;
			dq_oe <= IDLE_PINS;
		end else if (frame.start) begin
			phase <= PH_CMD;
			bits_left <= nbits_t'(`SPI_CMD_W);
			sending <= 1'b1;
			tx_done <= 1'b0;
			dq_out <= IDLE_PINS;
			dq_oe <= IDLE_PINS;
		end else if (shift) begin
			case (lane)
				`SPI_LANE_QUAD: begin
					dq_out <= shreg[SH_W-1 -: 4];
					dq_oe <= 4'b1111;
				end
				`SPI_LANE_DUAL: begin
					dq_out <= {2'b11, shreg[SH_W-1 -: 2]}; // DQ1 carries the earlier bit
					dq_oe <= 4'b1111;
				end
				default: begin
					dq_out <= {3'b110, shreg[SH_W-1]};
					dq_oe <= 4'b1101; // DQ1 stays an input
				end
			endcase
			if (bits_left == step) begin
				if (phase == PH_CMD && frame.has_addr) begin
					phase <= PH_ADDR;
					bits_left <= nbits_t'(`SPI_ADDR_W);
				end else if (phase != PH_TX && frame.has_tx) begin
					phase <= PH_TX;
					bits_left <= frame.tx_bits;
				end else begin
					phase <= PH_IDLE;
					bits_left <= '0;
				end
			end else begin
				bits_left <= bits_left - step;
			end
		end else if (latch_in && sending && phase == PH_IDLE) begin
			// Last bit has been sampled
			sending <= 1'b0;
			tx_done <= 1'b1;
			dq_out <= IDLE_PINS;
			dq_oe <= (frame.has_rx || frame.dummy_cycles != '0) ? 4'b0000 : IDLE_PINS;
		end
	end

endmodule

// ==== logic/spi_rx_shifter.sv ====
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_rx_shifter import spi_flash_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	spi_frame_if.rx    frame,
	input  logic       latch_out,
	input  logic       latch_in,
	input  logic       tx_done,
	input  logic [3:0] dq_in,
	output data_t      rx_data
);

	phase_t phase;
	dummy_t dummy_left;
	nbits_t rx_cnt;
	nbits_t step;
	logic   rx_wait;
	logic   dummy_step;

	always_comb begin
		case (frame.rx_lanes)
			`SPI_LANE_QUAD: step = nbits_t'(4);
			`SPI_LANE_DUAL: step = nbits_t'(2);
			default:        step = nbits_t'(1);
		endcase
	end

	// Read pending once the outgoing bits are done
	assign rx_wait = tx_done && frame.has_rx && (rx_cnt == '0);
	assign dummy_step = latch_out && (phase == PH_DUMMY || (phase == PH_IDLE && rx_wait));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_IDLE;
			dummy_left <= '0;
			rx_cnt <= '0;
			rx_data <= '0;
		end else if (frame.start) begin
			phase <= PH_IDLE;
			dummy_left <= frame.dummy_cycles;
			rx_cnt <= '0;
			rx_data <= '0;
		end else if (dummy_step) begin
			if (dummy_left == '0) begin
				phase <= PH_RX; // Sample from the next latch_in on
			end else begin
				dummy_left <= dummy_left - 1'b1;
				phase <= PH_DUMMY;
			end
		end else if (phase == PH_RX && latch_in) begin
			case (frame.rx_lanes)
				`SPI_LANE_QUAD: rx_data <= {rx_data[`SPI_DATA_W-5:0], dq_in};
				`SPI_LANE_DUAL: rx_data <= {rx_data[`SPI_DATA_W-3:0], dq_in[1:0]};
				default:        rx_data <= {rx_data[`SPI_DATA_W-2:0], dq_in[1]};
			endcase
			rx_cnt <= rx_cnt + step;
			if (rx_cnt + step >= frame.rx_bits)
				phase <= PH_IDLE;
		end
	end

endmodule

// ==== logic/spi_master_fl.sv ====
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_master_fl import spi_flash_pkg::*; #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL = 1,
	parameter int CPHA = 1
) (
	input  logic                  clk,
	input  logic                  rst,
	input  data_t                 data_in,
	output data_t                 data_out,
	input  addr_t                 address,
	input  cmd_t                  command,
	input  logic                  validflag,
	input  ctyp_t                 commtype,
	input  nbits_t                ndata_bits,
	input  dummy_t                dummy_cycles,
	input  logic [`SPI_FMT_W-1:0] frame_struct,
	output logic                  validflag_out,
	output logic                  tready,
	output logic                  sclk,
	output logic                  ss,
	inout  wire                   mosi_dq0,
	inout  wire                   miso_dq1,
	inout  wire                   wp_n_dq2,
	inout  wire                   hold_n_dq3
);

	logic       sclk_start, sclk_done;
	logic       latch_in, latch_out;
	logic       tx_done;
	edges_t     edge_count;
	data_t      rx_data;
	logic [3:0] dq_out, dq_oe, dq_in;

	spi_frame_if frame_bus ();

	spi_frame_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.data_in(data_in), .address(address), .command(command), .commtype(commtype),
		.ndata_bits(ndata_bits), .dummy_cycles(dummy_cycles), .frame_struct(frame_struct),
		.validflag(validflag), .rx_data(rx_data), .sclk_done(sclk_done),
		.frame(frame_bus.ctrl), .sclk_start(sclk_start), .edge_count(edge_count),
		.ss(ss), .tready(tready), .validflag_out(validflag_out), .data_out(data_out)
	);

	spi_sclk_gen #(
		.CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK), .CPOL(CPOL), .CPHA(CPHA)
	) u_sclk (
		.clk(clk), .rst(rst), .start(sclk_start), .edge_count(edge_count),
		.sclk(sclk), .latch_in(latch_in), .latch_out(latch_out), .done(sclk_done)
	);

	spi_tx_shifter u_tx (
		.clk(clk), .rst(rst), .frame(frame_bus.tx), .latch_out(latch_out), .latch_in(latch_in),
		.dq_out(dq_out), .dq_oe(dq_oe), .tx_done(tx_done)
	);

	spi_rx_shifter u_rx (
		.clk(clk), .rst(rst), .frame(frame_bus.rx), .latch_out(latch_out), .latch_in(latch_in),
		.tx_done(tx_done), .dq_in(dq_in), .rx_data(rx_data)
	);

	// Tristate pads
	assign mosi_dq0   = dq_oe[0] ? dq_out[0] : 1'bz;
	assign miso_dq1   = dq_oe[1] ? dq_out[1] : 1'bz;
	assign wp_n_dq2   = dq_oe[2] ? dq_out[2] : 1'bz;
	assign hold_n_dq3 = dq_oe[3] ? dq_out[3] : 1'bz;
	assign dq_in = {hold_n_dq3, wp_n_dq2, miso_dq1, mosi_dq0};

endmodule

// ==== tests/spi_flash_model.sv ====
`timescale 1ns/1ps

// Flash device for SPI mode 3, samples on rising SCLK, drives on falling SCLK
module spi_flash_model (
	input  logic        sclk,
	input  logic        ss,
	inout  wire         dq0,
	inout  wire         dq1,
	inout  wire         dq2,
	inout  wire         dq3,
	input  int          rd_first, // Falling edge that carries the first read bits
	input  int          rd_width, // Read lanes, 1, 2 or 4
	input  logic [31:0] rd_word   // Read data, left aligned
);

	logic [3:0]  cap [0:127]; // Pins seen at each rising edge
	int          edge_cnt;
	int          rise_cnt;
	int          fall_cnt;
	logic [31:0] rd_shift;
	logic [3:0]  drv_val;
	logic [3:0]  drv_oe;

	assign dq0 = drv_oe[0] ? drv_val[0] : 1'bz;
	assign dq1 = drv_oe[1] ? drv_val[1] : 1'bz;
	assign dq2 = drv_oe[2] ? drv_val[2] : 1'bz;
	assign dq3 = drv_oe[3] ? drv_val[3] : 1'bz;

	initial begin
		edge_cnt = 0;
		rise_cnt = 0;
		fall_cnt = 0;
		rd_shift = '0;
		drv_val = '0;
		drv_oe = '0;
	end

	// New frame
	always @(negedge ss) begin
		edge_cnt = 0;
		rise_cnt = 0;
		fall_cnt = 0;
		rd_shift = rd_word;
	end

	always @(posedge ss) drv_oe = 4'b0000; // Bus released between frames

	always @(posedge sclk) begin
		if (!ss) begin
			if (rise_cnt < 128)
				cap[rise_cnt] = {dq3, dq2, dq1, dq0};
			rise_cnt++;
			edge_cnt++;
		end
	end

	always @(negedge sclk) begin
		if (!ss) begin
			edge_cnt++;
			fall_cnt++;
			if (fall_cnt >= rd_first) begin
				case (rd_width)
					4: begin
						drv_val = rd_shift[31:28];
						drv_oe = 4'b1111;
						rd_shift = rd_shift << 4;
					end
					2: begin
						drv_val = {2'b00, rd_shift[31:30]}; // Earlier bit on DQ1
						drv_oe = 4'b0011;
						rd_shift = rd_shift << 2;
					end
					default: begin
						drv_val = {2'b00, rd_shift[31], 1'b0};
						drv_oe = 4'b0010;
						rd_shift = rd_shift << 1;
					end
				endcase
			end
		end
	end

endmodule

// ==== tests/spi_master_fl_tb.sv ====
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_master_fl_tb import spi_flash_pkg::*; ();

	localparam int HALF = 2;
	localparam int CPOL = 1;
	localparam int CPHA = 1;
	localparam int CLK_NS = 20;
	localparam int NFRAMES = 40;
	// Longest frame is 8 + 24 + 15 + 32 single lane cycles
	localparam int FRAME_CLKS = 2 * (8 + 24 + 15 + 32) * HALF + 24;
	localparam int TIMEOUT_NS = (NFRAMES * FRAME_CLKS + 40) * CLK_NS;

	logic                  clk;
	logic                  rst;
	data_t                 data_in;
	data_t                 data_out;
	addr_t                 address;
	cmd_t                  command;
	ctyp_t                 commtype;
	nbits_t                ndata_bits;
	dummy_t                dummy_cycles;
	logic [`SPI_FMT_W-1:0] frame_struct;
	logic                  validflag;
	logic                  validflag_out;
	logic                  tready;
	logic                  sclk;
	logic                  ss;
	wire                   dq0, dq1, dq2, dq3;
	int                    rd_first;
	int                    rd_width;
	logic [31:0]           rd_word;
	logic [31:0]           lfsr;
	logic [3:0]            exp_pins [$]; // Expected pins per transmit cycle
	logic [3:0]            exp_mask [$];

	spi_master_fl #(.CLKS_PER_HALF_SCLK(HALF), .CPOL(CPOL), .CPHA(CPHA)) UUT (
		.clk(clk), .rst(rst), .data_in(data_in), .data_out(data_out), .address(address),
		.command(command), .validflag(validflag), .commtype(commtype),
		.ndata_bits(ndata_bits), .dummy_cycles(dummy_cycles), .frame_struct(frame_struct),
		.validflag_out(validflag_out), .tready(tready), .sclk(sclk), .ss(ss),
		.mosi_dq0(dq0), .miso_dq1(dq1), .wp_n_dq2(dq2), .hold_n_dq3(dq3)
	);

	spi_flash_model flash (
		.sclk(sclk), .ss(ss), .dq0(dq0), .dq1(dq1), .dq2(dq2), .dq3(dq3),
		.rd_first(rd_first), .rd_width(rd_width), .rd_word(rd_word)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = next_lfsr(lfsr);
		end
	endtask

	function automatic int lane_width(input logic [1:0] code);
		case (code)
			2'b01:   return 2;
			2'b10:   return 4;
			default: return 1; // 11 runs single too
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// Appends one phase, MSB first, w bits per SCLK cycle
	task automatic add_phase(input logic [31:0] bits, input int nb, input int w);
		logic [3:0] chunk;
		for (int k = 0; k < nb; k += w) begin
			chunk = 4'((bits >> (nb - k - w)) & ((32'd1 << w) - 32'd1));
			if (w == 4) begin
				exp_pins.push_back(chunk);
				exp_mask.push_back(4'b1111);
			end else if (w == 2) begin
				exp_pins.push_back({2'b11, chunk[1:0]});
				exp_mask.push_back(4'b1111);
			end else begin
				exp_pins.push_back({3'b110, chunk[0]}); // DQ1 not driven
				exp_mask.push_back(4'b1101);
			end
		end
	endtask

	task automatic run_frame(input int idx);
		logic [31:0] r, word, rd_val;
		ctyp_t       ctyp;
		cmd_t        cmd;
		addr_t       addr;
		logic [7:0]  fmt;
		int          nb, dum_req, dum_eff, ncyc, total;
		logic        has_addr, has_tx, has_rx, prev_ss, prev_tready;

		rand_bits(3, r);
		ctyp = (idx < 8) ? 3'(idx) : r[2:0]; // Every code once, then random
		rand_bits(8, r);
		cmd = r[7:0];
		rand_bits(24, r);
		addr = r[23:0];
		rand_bits(32, word);
		rand_bits(2, r);
		nb = (int'(r[1:0]) + 1) * 8;
		rand_bits(4, r);
		dum_req = int'(r[3:0]);
		rand_bits(8, r);
		fmt = r[7:0];
		rand_bits(32, rd_val);
		if (nb < 32)
			rd_val = rd_val & ((32'd1 << nb) - 32'd1);

		has_addr = (ctyp == `SPI_CT_CMD_ADDR_RD || ctyp == `SPI_CT_CMD_ADDR_WR ||
			ctyp == `SPI_CT_CMD_ADDR);
		has_tx = (ctyp == `SPI_CT_CMD_WR || ctyp == `SPI_CT_CMD_ADDR_WR);
		has_rx = (ctyp == `SPI_CT_CMD_RD || ctyp == `SPI_CT_CMD_ADDR_RD);

		exp_pins.delete();
		exp_mask.delete();
		add_phase(32'(cmd), 8, lane_width(fmt[7:6]));
		if (has_addr)
			add_phase(32'(addr), 24, lane_width(fmt[5:4]));
		if (has_tx)
			add_phase(word >> (32 - nb), nb, lane_width(fmt[3:2]));
		ncyc = exp_pins.size();
		dum_eff = has_addr ? dum_req : 0;
		total = ncyc + dum_eff + (has_rx ? nb / lane_width(fmt[1:0]) : 0);

		@(posedge clk);
		data_in <= word;
		address <= addr;
		command <= cmd;
		commtype <= ctyp;
		ndata_bits <= nbits_t'(nb);
		dummy_cycles <= dummy_t'(dum_req);
		frame_struct <= fmt;
		validflag <= 1'b1;
		rd_first <= has_rx ? ncyc + dum_eff + 1 : 1 << 20;
		rd_width <= lane_width(fmt[1:0]);
		rd_word <= rd_val << (32 - nb);

		@(negedge clk);
		@(negedge clk); // Accepted
		check_value("tready", 32'(tready), 32'd0);
		check_value("ss", 32'(ss), 32'd1);
		@(negedge clk);
		check_value("ss", 32'(ss), 32'd0);
		prev_ss = ss;
		prev_tready = tready;
		while (validflag_out !== 1'b1) begin
			prev_ss = ss;
			prev_tready = tready;
			@(negedge clk);
		end
		check_value("ss before done", 32'(prev_ss), 32'd0);
		check_value("tready before done", 32'(prev_tready), 32'd0);
		check_value("ss", 32'(ss), 32'd1);
		check_value("tready", 32'(tready), 32'd1);
		check_value("sclk edges", 32'(flash.edge_cnt), 32'(2 * total));
		check_value("data_out", data_out, has_rx ? rd_val : 32'd0);
		for (int i = 0; i < ncyc; i++)
			check_value($sformatf("dq cycle %0d", i), 32'(flash.cap[i] & exp_mask[i]),
				32'(exp_pins[i]));

		// validflag still high, so no new frame may start
		repeat (3) begin
			@(negedge clk);
			check_value("validflag_out", 32'(validflag_out), 32'd0);
			check_value("tready", 32'(tready), 32'd1);
			check_value("ss", 32'(ss), 32'd1);
		end
		@(posedge clk);
		validflag <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		data_in = '0;
		address = '0;
		command = '0;
		commtype = '0;
		ndata_bits = '0;
		dummy_cycles = '0;
		frame_struct = '0;
		validflag = 1'b0;
		rd_first = 1 << 20;
		rd_width = 1;
		rd_word = '0;
		lfsr = 32'ha65b;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("tready", 32'(tready), 32'd1);
		check_value("ss", 32'(ss), 32'd1);
		check_value("validflag_out", 32'(validflag_out), 32'd0);
		check_value("sclk", 32'(sclk), 32'(CPOL));
		check_value("data_out", data_out, 32'd0);
		check_value("dq3:dq2", 32'({dq3, dq2}), 32'd3);
		for (int i = 0; i < NFRAMES; i++)
			run_frame(i);
		$display("All tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the frames did not finish within %0d ns", TIMEOUT_NS);
		$display("Some tests failed");
		$fatal(1);
	end

endmodule

// ==== spi_master_fl.f ====
+incdir+logic
logic/spi_flash_pkg.sv
logic/spi_frame_if.sv
logic/spi_sclk_gen.sv
logic/spi_frame_ctrl.sv
logic/spi_tx_shifter.sv
logic/spi_rx_shifter.sv
logic/spi_master_fl.sv
tests/spi_flash_model.sv
tests/spi_master_fl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= spi_master_fl_tb
FLIST     ?= spi_master_fl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FLIST)) logic/spi_flash_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
